//--- hw/alu.sv
// Single-cycle integer ALU for the register-register operations, instantiated by the execute top
module alu
    import rv_isa_pkg::*;
    import exu_pkg::*;
(
    input  alu_ctrl_t             ctrl_i,
    input  logic     [XLEN-1:0]   src1_i,
    input  logic     [XLEN-1:0]   src2_i,
    output logic     [XLEN-1:0]   rslt_o
);

    // ------------------------------
    // Shared adder and comparator
    // ------------------------------
    logic [XLEN+1:0] adder_a;
    logic [XLEN+1:0] adder_b;
    logic [XLEN+1:0] adder_sum;
    logic [XLEN-1:0] add_rslt;
    logic [XLEN-1:0] less_rslt;

    // Low bit pair supplies the +1 of the two's complement on subtract
    assign adder_a   = {ctrl_i.is_signed & src1_i[XLEN-1], src1_i, 1'b1};
    assign adder_b   = {ctrl_i.is_signed & src2_i[XLEN-1], src2_i, 1'b0} ^ {(XLEN+2){ctrl_i.is_neg}};
    assign adder_sum = adder_a + adder_b;
    assign add_rslt  = ctrl_i.is_add ? adder_sum[XLEN:1] : '0;
    assign less_rslt = {{(XLEN-1){1'b0}}, ctrl_i.is_less & adder_sum[XLEN+1]};  // Sign of difference

    // ------------------------------
    // Shifters and bitwise logic
    // ------------------------------
    logic        [4:0]    shamt;
    logic signed [XLEN:0] shr_src;
    logic        [XLEN:0] shr_full;
    logic [XLEN-1:0]      shl_rslt;
    logic [XLEN-1:0]      shr_rslt;
    logic [XLEN-1:0]      bit_rslt;

    assign shamt    = src2_i[4:0];                               // Upper bits ignored
    assign shr_src  = {ctrl_i.is_signed & src1_i[XLEN-1], src1_i};
    assign shr_full = shr_src >>> shamt;
    assign shl_rslt = ctrl_i.is_shift_left ? (src1_i << shamt) : '0;
    assign shr_rslt = ctrl_i.is_shift_right ? shr_full[XLEN-1:0] : '0;
    assign bit_rslt = (ctrl_i.is_xor_or ? (src1_i ^ src2_i) : '0)
                    | (ctrl_i.is_or_and ? (src1_i & src2_i) : '0);

    assign rslt_o = add_rslt | less_rslt | shl_rslt | shr_rslt | bit_rslt;

endmodule

//--- hw/divider.sv
// Iterative restoring divider for DIV, DIVU, REM and REMU, started by the execute top
module divider
    import rv_isa_pkg::*;
    import exu_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            start_i,
    input  div_ctrl_t       ctrl_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic            done_o,
    output logic [XLEN-1:0] rslt_o
);

    div_state_e      state;
    logic [4:0]      cntr;
    logic [XLEN-1:0] remainder;            // Holds the raw dividend until CHECK
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] divisor;
    logic            dividend_neg;
    logic            divisor_neg;
    logic            quot_neg;
    logic            rem_neg;
    logic            is_rem;

    logic [XLEN-1:0] dividend_mag;
    logic [XLEN-1:0] divisor_mag;
    logic [XLEN:0]   shifted;
    logic [XLEN+1:0] diff;
    logic            q_bit;
    logic            div_zero;

    assign dividend_mag = dividend_neg ? (~remainder + 1'b1) : remainder;
    assign divisor_mag  = divisor_neg ? (~divisor + 1'b1) : divisor;
    assign div_zero     = (divisor == '0);

    // One restoring step, borrow in the top bit
    assign shifted = {remainder, quotient[XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor};
    assign q_bit   = !diff[XLEN+1];

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= DIV_IDLE;
            cntr  <= '0;
        end else begin
            case (state)
                DIV_IDLE:  if (start_i) state <= DIV_CHECK;
                DIV_CHECK: begin
                    state <= div_zero ? DIV_RET : DIV_EXEC;
                    cntr  <= 5'(XLEN - 1);                    // 32 EXEC steps
                end
                DIV_EXEC: begin
                    if (cntr == '0) state <= DIV_RET;
                    cntr <= cntr - 1'b1;
                end
                default:   state <= DIV_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Datapath
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (state == DIV_IDLE && start_i) begin
            is_rem       <= ctrl_i.is_rem;
            dividend_neg <= ctrl_i.is_signed & src1_i[XLEN-1];
            divisor_neg  <= ctrl_i.is_signed & src2_i[XLEN-1];
            quot_neg     <= ctrl_i.is_signed & (src1_i[XLEN-1] ^ src2_i[XLEN-1]);
            rem_neg      <= ctrl_i.is_signed & src1_i[XLEN-1];  // Follows the dividend
            remainder    <= src1_i;
            divisor      <= src2_i;
        end else if (state == DIV_CHECK) begin
            if (div_zero) begin
                quotient <= '1;                                  // Remainder keeps dividend
                quot_neg <= 1'b0;
                rem_neg  <= 1'b0;
            end else begin
                remainder <= '0;
                quotient  <= dividend_mag;
                divisor   <= divisor_mag;
            end
        end else if (state == DIV_EXEC) begin
            remainder <= q_bit ? diff[XLEN-1:0] : shifted[XLEN-1:0];
            quotient  <= {quotient[XLEN-2:0], q_bit};
        end
    end

    assign done_o = (state == DIV_RET);
    assign rslt_o = (state != DIV_RET) ? '0 :
                    is_rem ? (rem_neg ? (~remainder + 1'b1) : remainder) :
                             (quot_neg ? (~quotient + 1'b1) : quotient);

endmodule

//--- hw/exu_decoder.sv
// Combinational decode of an OP-class instruction word into the execute control struct
module exu_decoder
    import rv_isa_pkg::*;
    import exu_pkg::*;
(
    input  logic [31:0] ir_i,
    output exu_ctrl_t   ctrl_o
);

    opcode_e    opcode;
    funct3_e    f3;
    logic [6:0] f7;
    logic       is_alt;

    assign opcode = opcode_e'(ir_i[6:0]);
    assign f3     = funct3_e'(ir_i[14:12]);
    assign f7     = ir_i[31:25];
    assign is_alt = (f7 == F7_ALT);

    always_comb begin
        ctrl_o      = '0;
        ctrl_o.unit = UNIT_NONE;
        if (opcode == OPC_OP) begin
            if (f7 == F7_MULDIV) begin
                ctrl_o.unit = f3[2] ? UNIT_DIV : UNIT_MUL;
                ctrl_o.mul.src1_signed = !f3[2] && (f3 == F3_SLL || f3 == F3_SLT);
                ctrl_o.mul.src2_signed = (f3 == F3_SLL);        // MULH only
                ctrl_o.mul.is_high     = !f3[2] && (f3 != F3_ADD);
                ctrl_o.div.is_signed   = (f3 == F3_XOR || f3 == F3_OR);  // DIV, REM
                ctrl_o.div.is_rem      = f3[2] && f3[1];
            end else if (f7 == F7_BASE || (is_alt && (f3 == F3_ADD || f3 == F3_SR))) begin
                ctrl_o.unit = UNIT_ALU;
                case (f3)
                    F3_ADD: begin
                        ctrl_o.alu.is_add = 1'b1;
                        ctrl_o.alu.is_neg = is_alt;             // SUB
                    end
                    F3_SLL:  ctrl_o.alu.is_shift_left = 1'b1;
                    F3_SLT: begin
                        ctrl_o.alu.is_signed = 1'b1;
                        ctrl_o.alu.is_neg    = 1'b1;
                        ctrl_o.alu.is_less   = 1'b1;
                    end
                    F3_SLTU: begin
                        ctrl_o.alu.is_neg  = 1'b1;
                        ctrl_o.alu.is_less = 1'b1;
                    end
                    F3_XOR:  ctrl_o.alu.is_xor_or = 1'b1;
                    F3_SR: begin
                        ctrl_o.alu.is_shift_right = 1'b1;
                        ctrl_o.alu.is_signed      = is_alt;     // SRA
                    end
                    F3_OR: begin
                        ctrl_o.alu.is_xor_or = 1'b1;            // (a^b)|(a&b)
                        ctrl_o.alu.is_or_and = 1'b1;
                    end
                    F3_AND:  ctrl_o.alu.is_or_and = 1'b1;
                endcase
            end
        end
    end

endmodule

//--- hw/exu_pkg.sv
// Control structs and state encodings of the execute unit, imported by every RTL module
package exu_pkg;

    // ------------------------------
    // Unit select
    // ------------------------------
    typedef enum logic [1:0] {
        UNIT_ALU  = 2'd0,
        UNIT_MUL  = 2'd1,
        UNIT_DIV  = 2'd2,
        UNIT_NONE = 2'd3                   // Illegal instruction
    } exu_unit_e;

    // ------------------------------
    // Per-unit control
    // ------------------------------
    typedef struct packed {
        logic is_signed;                   // Sign-extend operands (SLT, SRA)
        logic is_neg;                      // Invert src2 for subtract
        logic is_less;                     // Take the sign of the difference
        logic is_add;                      // Take the adder sum
        logic is_shift_left;
        logic is_shift_right;
        logic is_xor_or;                   // XOR, and OR together with is_or_and
        logic is_or_and;                   // AND, and OR together with is_xor_or
    } alu_ctrl_t;

    typedef struct packed {
        logic src1_signed;
        logic src2_signed;
        logic is_high;                     // Return upper product half
    } mul_ctrl_t;

    typedef struct packed {
        logic is_signed;
        logic is_rem;                      // Return remainder, not quotient
    } div_ctrl_t;

    typedef struct packed {
        exu_unit_e unit;
        alu_ctrl_t alu;
        mul_ctrl_t mul;
        div_ctrl_t div;
    } exu_ctrl_t;

    typedef enum logic [1:0] {MUL_IDLE, MUL_EXEC, MUL_RET} mul_state_e;

    typedef enum logic [1:0] {DIV_IDLE, DIV_CHECK, DIV_EXEC, DIV_RET} div_state_e;

endpackage

//--- hw/exu_top.sv
// Register-register execute unit top, takes one strobed OP instruction and returns a registered result
module exu_top
    import rv_isa_pkg::*;
    import exu_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            valid_i,
    input  logic [31:0]     ir_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic            valid_o,
    output logic [XLEN-1:0] rslt_o,
    output logic            illegal_o,
    output logic            busy_o
);

    exu_ctrl_t       ctrl;
    logic            accept;
    logic            mul_start;
    logic            div_start;
    logic [XLEN-1:0] alu_rslt;
    logic            mul_done;
    logic [XLEN-1:0] mul_rslt;
    logic            div_done;
    logic [XLEN-1:0] div_rslt;
    logic            alu_valid_q;
    logic [XLEN-1:0] alu_rslt_q;
    logic            illegal_q;
    logic            busy_q;

    // ------------------------------
    // Decode and dispatch
    // ------------------------------
    exu_decoder u_dec (.ir_i(ir_i), .ctrl_o(ctrl));

    assign accept    = valid_i && !busy_q;                 // Strobes while busy are dropped
    assign mul_start = accept && (ctrl.unit == UNIT_MUL);
    assign div_start = accept && (ctrl.unit == UNIT_DIV);

    alu u_alu (.ctrl_i(ctrl.alu), .src1_i(src1_i), .src2_i(src2_i), .rslt_o(alu_rslt));

    multiplier u_mul (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(mul_start), .ctrl_i(ctrl.mul),
        .src1_i(src1_i), .src2_i(src2_i), .done_o(mul_done), .rslt_o(mul_rslt)
    );

    divider u_div (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(div_start), .ctrl_i(ctrl.div),
        .src1_i(src1_i), .src2_i(src2_i), .done_o(div_done), .rslt_o(div_rslt)
    );

    // ------------------------------
    // Result merge
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            alu_valid_q <= 1'b0;
            illegal_q   <= 1'b0;
            busy_q      <= 1'b0;
        end else begin
            alu_valid_q <= accept && (ctrl.unit == UNIT_ALU);
            illegal_q   <= accept && (ctrl.unit == UNIT_NONE);
            busy_q      <= (busy_q && !(mul_done || div_done)) || mul_start || div_start;
        end
    end

    always_ff @(posedge clk_i) begin
        alu_rslt_q <= alu_rslt;
    end

    assign valid_o   = alu_valid_q | mul_done | div_done;
    assign rslt_o    = (alu_valid_q ? alu_rslt_q : '0) | mul_rslt | div_rslt;  // Idle units give 0
    assign illegal_o = illegal_q;
    assign busy_o    = busy_q;

endmodule

//--- hw/multiplier.sv
// Two-step 33x33 signed multiplier for MUL, MULH, MULHSU and MULHU, started by the execute top
module multiplier
    import rv_isa_pkg::*;
    import exu_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            start_i,
    input  mul_ctrl_t       ctrl_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic            done_o,
    output logic [XLEN-1:0] rslt_o
);

    mul_state_e             state;
    logic signed [XLEN:0]   mcand;
    logic signed [XLEN:0]   mplier;
    logic signed [2*XLEN+1:0] full_prod;
    logic [2*XLEN-1:0]      product;
    logic                   is_high;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: if (start_i) state <= MUL_EXEC;
                MUL_EXEC: state <= MUL_RET;
                default:  state <= MUL_IDLE;                    // RET lasts one cycle
            endcase
        end
    end

    assign full_prod = mcand * mplier;

    always_ff @(posedge clk_i) begin
        if (state == MUL_IDLE) begin                             // Track inputs until started
            mcand   <= {ctrl_i.src1_signed & src1_i[XLEN-1], src1_i};
            mplier  <= {ctrl_i.src2_signed & src2_i[XLEN-1], src2_i};
            is_high <= ctrl_i.is_high;
        end
        if (state == MUL_EXEC) begin
            product <= full_prod[2*XLEN-1:0];
        end
    end

    assign done_o = (state == MUL_RET);
    assign rslt_o = (state != MUL_RET) ? '0 :
                    is_high ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

endmodule

//--- hw/rv_isa_pkg.sv
// RV32 instruction encodings and data width shared by the decoder, datapath units and testbench
package rv_isa_pkg;

    // ------------------------------
    // Data width
    // ------------------------------
    localparam int XLEN = 32;              // RV32 register width

    // ------------------------------
    // Major opcodes, only OP is executed
    // ------------------------------
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,           // Register-register class
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 of the OP class, M-extension ops reuse the same codes
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,                  // ADD/SUB, MUL
        F3_SLL  = 3'b001,                  // MULH
        F3_SLT  = 3'b010,                  // MULHSU
        F3_SLTU = 3'b011,                  // MULHU
        F3_XOR  = 3'b100,                  // DIV
        F3_SR   = 3'b101,                  // SRL/SRA, DIVU
        F3_OR   = 3'b110,                  // REM
        F3_AND  = 3'b111                   // REMU
    } funct3_e;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB, SRA
    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // M extension

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module exu_tb -f sim.f
out=$(./obj_dir/Vexu_tb)
echo "$out"
if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

//--- sim.f
hw/rv_isa_pkg.sv
hw/exu_pkg.sv
hw/exu_decoder.sv
hw/alu.sv
hw/multiplier.sv
hw/divider.sv
hw/exu_top.sv
verif/exu_sva.sv
verif/exu_tb.sv

//--- verif/exu_sva.sv
// Output protocol assertions for the execute unit, attached to exu_top by bind
module exu_sva
    import rv_isa_pkg::*;
    import exu_pkg::*;
(
    input logic            clk_i,
    input logic            rst_i,
    input logic            accept_i,
    input exu_unit_e       unit_i,
    input logic            mul_start_i,
    input logic            valid_i,
    input logic [XLEN-1:0] rslt_i,
    input logic            illegal_i
);

    a_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(valid_i && illegal_i))
        else $error("valid_o and illegal_o high together");

    a_zero: assert property (@(posedge clk_i) disable iff (rst_i) !valid_i |-> rslt_i == '0)
        else $error("rslt_o not zero without valid_o");

    a_alu: assert property (@(posedge clk_i) disable iff (rst_i)
                            accept_i && unit_i == UNIT_ALU |=> valid_i)
        else $error("ALU result not valid on the next cycle");

    a_mul: assert property (@(posedge clk_i) disable iff (rst_i) mul_start_i |-> ##2 valid_i)
        else $error("multiply result not valid two cycles after accept");

endmodule

bind exu_top exu_sva u_sva (
    .clk_i(clk_i), .rst_i(rst_i), .accept_i(accept), .unit_i(ctrl.unit),
    .mul_start_i(mul_start), .valid_i(valid_o), .rslt_i(rslt_o), .illegal_i(illegal_o)
);

//--- verif/exu_tb.sv
// Directed testbench for the execute unit, runs ALU, multiply, divide, busy and illegal tests
module exu_tb
    import rv_isa_pkg::*;
();

    localparam int RESULT_TIMEOUT = 100;   // Cycles allowed per result

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_ir;
    logic [31:0] in_src1;
    logic [31:0] in_src2;
    logic        out_valid;
    logic [31:0] out_rslt;
    logic        out_illegal;
    logic        out_busy;
    integer      seed = 32'h9187_bd07;
    int          n_checks = 0;
    int          n_errors = 0;

    exu_top dut0 (
        .clk_i(clk), .rst_i(rst), .valid_i(in_valid), .ir_i(in_ir), .src1_i(in_src1),
        .src2_i(in_src2), .valid_o(out_valid), .rslt_o(out_rslt), .illegal_o(out_illegal),
        .busy_o(out_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Reference model and helpers
    // ------------------------------
    function automatic logic [31:0] make_instr(input logic [6:0] f7, input funct3_e f3,
                                               input opcode_e opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};   // rs2=x2, rs1=x1, rd=x3
    endfunction

    function automatic logic [31:0] model_result(input logic [6:0] f7, input funct3_e f3,
                                                 input logic [31:0] a, input logic [31:0] b);
        int          sa;
        int          sb;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        logic        ovf;
        logic [31:0] r;
        sa  = a;
        sb  = b;
        ea  = {32'b0, a};
        eb  = {32'b0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        r   = '0;
        if (f7 == F7_MULDIV) begin
            if (f3 == F3_SLL || f3 == F3_SLT) ea = {{32{a[31]}}, a};  // MULH, MULHSU
            if (f3 == F3_SLL) eb = {{32{b[31]}}, b};
            prod = ea * eb;
            case (f3)
                F3_ADD:  r = prod[31:0];
                F3_XOR: begin                                     // DIV
                    if (b == 0) r = '1;
                    else if (ovf) r = a;
                    else r = sa / sb;
                end
                F3_SR:   r = (b == 0) ? '1 : a / b;               // DIVU
                F3_OR: begin                                      // REM
                    if (b == 0) r = a;
                    else if (ovf) r = '0;
                    else r = sa % sb;
                end
                F3_AND:  r = (b == 0) ? a : a % b;                // REMU
                default: r = prod[63:32];
            endcase
        end else begin
            case (f3)
                F3_ADD:  r = (f7 == F7_ALT) ? a - b : a + b;
                F3_SLL:  r = a << b[4:0];
                F3_SLT:  r = {31'b0, sa < sb};
                F3_SLTU: r = {31'b0, a < b};
                F3_XOR:  r = a ^ b;
                F3_SR: begin
                    if (f7 == F7_ALT) r = sa >>> b[4:0];          // SRA keeps the sign
                    else r = a >> b[4:0];
                end
                F3_OR:   r = a | b;
                F3_AND:  r = a & b;
            endcase
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s gave %08h, expected %08h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        n_checks++;
        assert (got == exp) else begin
            $display("mismatch at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %s finished, %0d errors", name, n_errors - start_errors);
    endtask

    task automatic issue(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        in_valid = 1'b1;
        in_ir    = instr;
        in_src1  = a;
        in_src2  = b;
        @(negedge clk);
        in_valid = 1'b0;                    // One-cycle strobe
    endtask

    // Starts at the first falling edge after the accept edge
    task automatic wait_result(input string what, output int lat, output bit timed_out);
        lat = 1;
        while (!(out_valid || out_illegal) && lat < RESULT_TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        timed_out = !(out_valid || out_illegal);
        if (timed_out) begin
            $display("timeout: %s gave no result within %0d cycles", what, RESULT_TIMEOUT);
            n_errors++;
        end
    endtask

    task automatic run_op(input logic [6:0] f7, input funct3_e f3, input logic [31:0] a,
                          input logic [31:0] b, input int exp_lat);
        string       what;
        logic [31:0] expected;
        int          lat;
        bit          timed_out;
        what     = $sformatf("f7=%02h f3=%0d a=%08h b=%08h", f7, f3, a, b);
        expected = model_result(f7, f3, a, b);
        issue(make_instr(f7, f3, OPC_OP), a, b);
        wait_result(what, lat, timed_out);
        if (!timed_out) begin
            check_value({what, " valid_o"}, 32'(out_valid), 32'd1);
            check_value(what, out_rslt, expected);
            check_latency(what, lat, exp_lat);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_alu_ops();
        int      start;
        int      i;
        int      j;
        logic [6:0] f7;
        funct3_e f3;
        start = n_errors;
        for (i = 0; i < 10; i++) begin
            f7 = (i < 8) ? F7_BASE : F7_ALT;
            f3 = (i == 9) ? F3_SR : funct3_e'(3'(i));       // 8 wraps to ADD, giving SUB
            for (j = 0; j < 3; j++) run_op(f7, f3, $random(seed), $random(seed), 1);
        end
        for (i = 0; i < 2; i++) begin                      // Opposite signs
            f3 = i ? F3_SLTU : F3_SLT;
            run_op(F7_BASE, f3, 32'hFFFF_FFFB, 32'd3, 1);
            run_op(F7_BASE, f3, 32'd3, 32'hFFFF_FFFB, 1);
        end
        run_op(F7_ALT, F3_SR, 32'h8000_00F0, 32'd4, 1);
        run_op(F7_ALT, F3_SR, 32'hFFFF_FFFF, 32'd31, 1);
        run_op(F7_BASE, F3_SLL, 32'h9234_5678, 32'hFFFF_FFE5, 1);  // Shift amount 5
        run_op(F7_BASE, F3_SR, 32'h9234_5678, 32'hFFFF_FFE5, 1);
        run_op(F7_ALT, F3_SR, 32'h9234_5678, 32'hFFFF_FFE5, 1);
        report_test("alu_ops", start);
    endtask

    task automatic test_mul_ops();
        int          start;
        int          i;
        int          j;
        logic [31:0] a;
        logic [31:0] b;
        start = n_errors;
        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 3; j++) run_op(F7_MULDIV, funct3_e'(3'(i)), $random(seed),
                                           $random(seed), 2);
            for (j = 0; j < 4; j++) begin
                a = j[0] ? 32'hFFFF_FFFF : 32'h8000_0000;
                b = j[1] ? 32'hFFFF_FFFF : 32'h8000_0000;
                run_op(F7_MULDIV, funct3_e'(3'(i)), a, b, 2);
            end
        end
        report_test("mul_ops", start);
    endtask

    task automatic test_div_ops();
        int          start;
        int          i;
        int          j;
        logic [31:0] a;
        logic [31:0] b;
        start = n_errors;
        for (i = 4; i < 8; i++) begin
            for (j = 0; j < 3; j++) begin
                a = $random(seed);
                b = $random(seed);
                if (j == 2) b = {{20{b[31]}}, b[11:0]};    // Small divisor, either sign
                if (b == 0) b = 32'd3;
                run_op(F7_MULDIV, funct3_e'(3'(i)), a, b, 34);
            end
            for (j = 0; j < 4; j++) begin
                a = j[0] ? -32'd37 : 32'd37;
                b = j[1] ? -32'd5 : 32'd5;
                run_op(F7_MULDIV, funct3_e'(3'(i)), a, b, 34);
            end
        end
        report_test("div_ops", start);
    endtask

    task automatic test_div_corners();
        int start;
        int i;
        start = n_errors;
        for (i = 4; i < 8; i++) begin
            run_op(F7_MULDIV, funct3_e'(3'(i)), $random(seed), 32'd0, 2);
            run_op(F7_MULDIV, funct3_e'(3'(i)), 32'h8000_0000, 32'hFFFF_FFFF, 34);
        end
        report_test("div_corners", start);
    endtask

    task automatic test_busy_ignore();
        int          start;
        int          lat;
        int          i;
        bit          timed_out;
        bit          extra;
        logic [31:0] a;
        logic [31:0] expected;
        start    = n_errors;
        a        = $random(seed);
        expected = model_result(F7_MULDIV, F3_SR, a, 32'd7);
        issue(make_instr(F7_MULDIV, F3_SR, OPC_OP), a, 32'd7);  // DIVU
        check_value("busy_o during divide", 32'(out_busy), 32'd1);
        repeat (3) @(negedge clk);
        in_valid = 1'b1;                    // ADD strobe while busy
        in_ir    = make_instr(F7_BASE, F3_ADD, OPC_OP);
        in_src1  = 32'd1;
        in_src2  = 32'd2;
        @(negedge clk);
        in_valid = 1'b0;
        wait_result("divide behind ignored strobe", lat, timed_out);
        if (!timed_out) check_value("divide behind ignored strobe", out_rslt, expected);
        extra = 1'b0;
        for (i = 0; i < 40; i++) begin
            @(negedge clk);
            if (out_valid || out_illegal) extra = 1'b1;
        end
        n_checks++;
        assert (!extra) else begin
            $display("a strobe given while busy produced a second result");
            n_errors++;
        end
        report_test("busy_ignore", start);
    endtask

    task automatic test_illegal();
        int          start;
        int          i;
        int          lat;
        bit          timed_out;
        logic [31:0] instr;
        start = n_errors;
        for (i = 0; i < 2; i++) begin
            instr = (i == 0) ? make_instr(F7_BASE, F3_ADD, OPC_OP_IMM)
                             : make_instr(F7_ALT, F3_SLL, OPC_OP);
            issue(instr, $random(seed), $random(seed));
            wait_result("illegal instruction", lat, timed_out);
            if (!timed_out) begin
                check_value("illegal_o", 32'(out_illegal), 32'd1);
                check_value("valid_o with illegal", 32'(out_valid), 32'd0);
                check_value("rslt_o with illegal", out_rslt, 32'd0);
                check_latency("illegal instruction", lat, 1);
            end
        end
        report_test("illegal", start);
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_ir    = '0;
        in_src1  = '0;
        in_src2  = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_value("outputs after reset", {29'b0, out_valid, out_illegal, out_busy}, '0);
        test_alu_ops();
        test_mul_ops();
        test_div_ops();
        test_div_corners();
        test_busy_ignore();
        test_illegal();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
